// ==== uart_tx_sub.f ====
+incdir+include
logic/uart_tx_pkg.sv
logic/uart_line_ctrl_if.sv
logic/uart_host_port.sv
logic/uart_tx_fifo.sv
logic/uart_baud_gen.sv
logic/uart_tx_serializer.sv
logic/uart_tx_top.sv
verification/uart_tx_sva.sv
verification/uart_tx_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = uart_tx_tb
FILELIST  = uart_tx_sub.f
OBJDIR    = obj_dir
PASS_MSG  = Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== verification/uart_tx_tb.sv ====
// testbench for the transmit subsystem, compiled with the file list and run as the top module.
`timescale 1ns/100ps
`include "uart_tx_consts.svh"

module uart_tx_tb;
	import uart_tx_pkg::*;

	// divisor 1 and sixteen ticks per bit.
	localparam int BIT_CYC     = 16 * 2;
	localparam int NUM_FRAMES  = 28;
	localparam int CYCLE_LIMIT = NUM_FRAMES * 12 * 16 * 2 + 2000;

	logic       uclk;
	logic       urstn;
	logic       wr_en;
	logic [1:0] wr_addr;
	logic [7:0] wr_data;
	logic       uart_sout;
	logic       unloop_sout;
	logic       uart_tx_busy;
	logic       tx_full;
	logic       tx_overrun;
	uart_lcr_t  cur_lcr;
	logic [31:0] lcg_state = 32'hb359_178f;
	int         err_count = 0;
	int         cycle_cnt = 0;

	uart_tx_top UUT (
		.uclk         (uclk),
		.urstn        (urstn),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.uart_sout    (uart_sout),
		.unloop_sout  (unloop_sout),
		.uart_tx_busy (uart_tx_busy),
		.tx_full      (tx_full),
		.tx_overrun   (tx_overrun)
	);

	initial begin
		uclk = 1'b0;
		forever begin
			#20 uclk = ~uclk;
		end
	end

	always @(posedge uclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: test did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	// ********************
	// helpers.
	function automatic logic [7:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[23:16];
	endfunction

	function automatic void check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			err_count++;
			$display("Error at %0t: %s expected %b, got %b", $time, name, exp, act);
		end
	endfunction

	task automatic host_write(input logic [1:0] addr, input logic [7:0] data);
		@(negedge uclk);
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge uclk);
		wr_en   = 1'b0;
	endtask

	task automatic set_lcr(input logic [1:0] wl, input logic par_en, input logic par_even,
		input logic par_stick, input logic stop2, input logic brk);
		uart_reg_word_u w;
		w.raw                   = 8'h00;
		w.lcr.lcr_wordlength    = wl;
		w.lcr.lcr_parity_enable = par_en;
		w.lcr.lcr_parity_even   = par_even;
		w.lcr.lcr_parity_stick  = par_stick;
		w.lcr.lcr_stopbit       = stop2;
		w.lcr.lcr_break         = brk;
		cur_lcr = w.lcr;
		host_write(`UART_ADDR_LCR, w.raw);
	endtask

	// returns on the first falling edge after the start bit begins.
	task automatic wait_for_start();
		logic prev;
		prev = unloop_sout;
		@(negedge uclk);
		while (!(prev && !unloop_sout)) begin
			prev = unloop_sout;
			@(negedge uclk);
		end
	endtask

	// reference frame from the character and the current line control.
	task automatic check_frame(input logic [7:0] ch, input bit cont, input bit more);
		logic exp_lvl [$];
		int   dur [$];
		int   nbits;
		int   pos;
		int   off;
		int   target;
		int   i;
		logic par;
		nbits = int'(cur_lcr.lcr_wordlength) + 5;
		par   = 1'b0;
		exp_lvl.push_back(1'b0);
		dur.push_back(BIT_CYC);
		for (i = 0; i < nbits; i++) begin
			exp_lvl.push_back(ch[i]);
			dur.push_back(BIT_CYC);
			par = par ^ ch[i];
		end
		if (cur_lcr.lcr_parity_enable) begin
			if (cur_lcr.lcr_parity_stick) begin
				exp_lvl.push_back(~cur_lcr.lcr_parity_even);
			end else if (cur_lcr.lcr_parity_even) begin
				exp_lvl.push_back(par);
			end else begin
				exp_lvl.push_back(~par);
			end
			dur.push_back(BIT_CYC);
		end
		exp_lvl.push_back(1'b1);
		dur.push_back(BIT_CYC);
		if (cur_lcr.lcr_stopbit) begin
			exp_lvl.push_back(1'b1);
			dur.push_back(cur_lcr.lcr_wordlength == 2'd0 ? BIT_CYC / 2 : BIT_CYC);
		end
		// a following frame must start right on the previous stop end.
		if (cont) begin
			check_bit("unloop_sout", 1'b0, unloop_sout);
		end else begin
			wait_for_start();
		end
		pos = 0;
		off = 0;
		foreach (exp_lvl[k]) begin
			target = off + dur[k] / 2;
			repeat (target - pos) @(negedge uclk);
			pos = target;
			check_bit("unloop_sout", exp_lvl[k], unloop_sout);
			check_bit("uart_tx_busy", 1'b1, uart_tx_busy);
			off = off + dur[k];
		end
		repeat (off - pos) @(negedge uclk);
		if (!more) begin
			check_bit("uart_tx_busy", 1'b0, uart_tx_busy);
			check_bit("unloop_sout", 1'b1, unloop_sout);
		end
	endtask

	task automatic send_and_check(input logic [7:0] ch);
		host_write(`UART_ADDR_THR, ch);
		check_frame(ch, 1'b0, 1'b0);
	endtask

	// ********************
	// test sequence.
	initial begin
		logic [7:0]     burst [`UART_TX_FIFO_DEPTH + 2];
		uart_reg_word_u w;
		int             i;
		int             j;
		int             k;
		urstn   = 1'b0;
		wr_en   = 1'b0;
		wr_addr = 2'd0;
		wr_data = 8'h00;
		cur_lcr = '0;
		repeat (5) @(negedge uclk);
		urstn = 1'b1;
		repeat (4) @(negedge uclk);
		check_bit("uart_sout", 1'b1, uart_sout);
		check_bit("uart_tx_busy", 1'b0, uart_tx_busy);
		check_bit("tx_full", 1'b0, tx_full);
		check_bit("tx_overrun", 1'b0, tx_overrun);
		host_write(`UART_ADDR_DIV, 8'h01);

		for (i = 0; i < 4; i++) begin
			set_lcr(i[1:0], 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
			send_and_check(next_rand());
		end

		// odd, even, then stick one and stick zero.
		set_lcr(2'd3, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
		send_and_check(next_rand());
		set_lcr(2'd3, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
		send_and_check(next_rand());
		set_lcr(2'd3, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
		send_and_check(next_rand());
		set_lcr(2'd3, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
		send_and_check(next_rand());

		set_lcr(2'd3, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
		send_and_check(next_rand());
		set_lcr(2'd0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
		send_and_check(next_rand());

		// one character leaves during the burst, so depth plus one are kept.
		set_lcr(2'd3, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
		for (i = 0; i < `UART_TX_FIFO_DEPTH + 2; i++) begin
			burst[i] = next_rand();
		end
		fork
			begin
				for (j = 0; j < `UART_TX_FIFO_DEPTH + 2; j++) begin
					@(negedge uclk);
					wr_en   = 1'b1;
					wr_addr = `UART_ADDR_THR;
					wr_data = burst[j];
				end
				@(negedge uclk);
				wr_en = 1'b0;
				@(negedge uclk);
				check_bit("tx_full", 1'b1, tx_full);
				check_bit("tx_overrun", 1'b1, tx_overrun);
			end
			begin
				for (k = 0; k <= `UART_TX_FIFO_DEPTH; k++) begin
					check_frame(burst[k], k != 0, k != `UART_TX_FIFO_DEPTH);
				end
			end
		join
		check_bit("tx_full", 1'b0, tx_full);

		set_lcr(2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1);
		repeat (40) @(negedge uclk);
		check_bit("uart_sout", 1'b0, uart_sout);
		check_bit("unloop_sout", 1'b0, unloop_sout);
		set_lcr(2'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		repeat (4) @(negedge uclk);

		w.raw            = 8'h00;
		w.ctrl.loop_mode = 1'b1;
		host_write(`UART_ADDR_CTRL, w.raw);
		set_lcr(2'd3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		send_and_check(next_rand());
		host_write(`UART_ADDR_CTRL, 8'h00);
		repeat (4) @(negedge uclk);

		$display("errors: %0d, assertion failures: %0d", err_count, UUT.u_sva.assert_fails);
		if (err_count == 0 && UUT.u_sva.assert_fails == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== verification/uart_tx_sva.sv ====
// concurrent checks on the transmit top, attached to uart_tx_top by the bind below.
`timescale 1ns/100ps

module uart_tx_sva (
	input logic uclk,
	input logic urstn,
	input logic uart_sout,
	input logic unloop_sout,
	input logic uart_tx_busy,
	input logic tx_overrun,
	input logic tx_data_ready,
	input logic txfifo_read,
	input logic lcr_break,
	input logic loop_mode
);
	int assert_fails = 0;

	// ********************
	// line levels.
	reset_idle_a: assert property (@(posedge uclk)
		$rose(urstn) |-> (!uart_tx_busy && uart_sout && unloop_sout && !tx_overrun))
	else begin
		assert_fails++;
		$error("transmitter not idle when reset was released");
	end

	// mark level when nothing is being sent.
	idle_mark_a: assert property (@(posedge uclk) disable iff (!urstn)
		(!uart_tx_busy && !lcr_break) |-> (uart_sout && unloop_sout))
	else begin
		assert_fails++;
		$error("line not at mark while idle");
	end

	break_low_a: assert property (@(posedge uclk) disable iff (!urstn)
		(lcr_break && !loop_mode) |-> (!uart_sout && !unloop_sout))
	else begin
		assert_fails++;
		$error("line not low while break is set");
	end

	loop_mark_a: assert property (@(posedge uclk) disable iff (!urstn)
		loop_mode |-> uart_sout)
	else begin
		assert_fails++;
		$error("pin output moved during loopback");
	end

	pin_follows_a: assert property (@(posedge uclk) disable iff (!urstn)
		!loop_mode |-> (uart_sout == unloop_sout))
	else begin
		assert_fails++;
		$error("pin output differs from unlooped output");
	end

	// ********************
	// fifo and status.
	overrun_sticky_a: assert property (@(posedge uclk) disable iff (!urstn)
		tx_overrun |=> tx_overrun)
	else begin
		assert_fails++;
		$error("overrun flag cleared without reset");
	end

	busy_fall_a: assert property (@(posedge uclk) disable iff (!urstn)
		$fell(uart_tx_busy) |-> !$past(tx_data_ready))
	else begin
		assert_fails++;
		$error("busy dropped while a character was waiting");
	end

	pop_nonempty_a: assert property (@(posedge uclk) disable iff (!urstn)
		txfifo_read |-> tx_data_ready)
	else begin
		assert_fails++;
		$error("fifo read pulse with an empty fifo");
	end

endmodule

bind uart_tx_top uart_tx_sva u_sva (
	.uclk          (uclk),
	.urstn         (urstn),
	.uart_sout     (uart_sout),
	.unloop_sout   (unloop_sout),
	.uart_tx_busy  (uart_tx_busy),
	.tx_overrun    (tx_overrun),
	.tx_data_ready (tx_data_ready),
	.txfifo_read   (txfifo_read),
	.lcr_break     (line_if.lcr_break),
	.loop_mode     (line_if.uart_loop_mode)
);

// ==== logic/uart_tx_top.sv ====
// transmit subsystem top, connects host port, fifo, baud generator and serializer.
`timescale 1ns/100ps

module uart_tx_top (
	input  logic       uclk,
	input  logic       urstn,
	input  logic       wr_en,
	input  logic [1:0] wr_addr,
	input  logic [7:0] wr_data,
	output logic       uart_sout,
	output logic       unloop_sout,
	output logic       uart_tx_busy,
	output logic       tx_full,
	output logic       tx_overrun
);
	logic       push;
	logic [7:0] push_data;
	logic [7:0] baud_div;
	logic       baud_mx;
	logic [7:0] txfifo_dataout;
	logic       tx_data_ready;
	logic       txfifo_read;

	uart_line_ctrl_if line_if ();

	uart_host_port u_host_port (
		.uclk       (uclk),
		.urstn      (urstn),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.full       (tx_full),
		.push       (push),
		.push_data  (push_data),
		.baud_div   (baud_div),
		.tx_overrun (tx_overrun),
		.line       (line_if.host)
	);

	uart_tx_fifo u_tx_fifo (
		.uclk           (uclk),
		.urstn          (urstn),
		.push           (push),
		.push_data      (push_data),
		.txfifo_read    (txfifo_read),
		.txfifo_dataout (txfifo_dataout),
		.tx_data_ready  (tx_data_ready),
		.full           (tx_full)
	);

	uart_baud_gen u_baud_gen (
		.uclk     (uclk),
		.urstn    (urstn),
		.baud_div (baud_div),
		.baud_mx  (baud_mx)
	);

	uart_tx_serializer u_tx_serializer (
		.uclk           (uclk),
		.urstn          (urstn),
		.baud_mx        (baud_mx),
		.txfifo_dataout (txfifo_dataout),
		.tx_data_ready  (tx_data_ready),
		.line           (line_if.tx),
		.txfifo_read    (txfifo_read),
		.uart_tx_busy   (uart_tx_busy),
		.uart_sout      (uart_sout),
		.unloop_sout    (unloop_sout)
	);

endmodule

// ==== logic/uart_tx_serializer.sv ====
// transmit frame serializer, turns fifo characters into start, data, parity and stop bits.
`timescale 1ns/100ps

module uart_tx_serializer (
	input  logic         uclk,
	input  logic         urstn,
	input  logic         baud_mx,
	input  logic [7:0]   txfifo_dataout,
	input  logic         tx_data_ready,
	uart_line_ctrl_if.tx line,
	output logic         txfifo_read,
	output logic         uart_tx_busy,
	output logic         uart_sout,
	output logic         unloop_sout
);
	// data states carry the bit index in the low three bits.
	localparam logic [3:0] TX_IDLE   = 4'b0000;
	localparam logic [3:0] TX_START  = 4'b0100;
	localparam logic [3:0] TX_DATA0  = 4'b1000;
	localparam logic [3:0] TX_PARITY = 4'b0111;
	localparam logic [3:0] TX_STOP1  = 4'b0011;
	localparam logic [3:0] TX_STOP15 = 4'b0010;
	localparam logic [3:0] TX_STOP2  = 4'b0001;

	logic [3:0] state_q;
	logic [3:0] state_d;
	logic [3:0] bit_cnt;
	logic [3:0] bit_last;
	logic [3:0] half_ticks;
	logic       bit_end;
	logic       half_end;
	logic       cnt_clr;
	logic       in_data;
	logic [2:0] last_bit;
	logic [3:0] after_data;
	logic [3:0] after_stop;
	logic       load;
	logic       shift_en;
	logic [7:0] shift_q;
	logic       parity_q;
	logic       parity_bit;
	logic       line_lvl;

	// ********************
	// bit period timing.

	// oversample 0 wraps to 15, giving sixteen ticks.
	assign bit_last = line.oversample - 4'd1;

	always_comb begin
		if (line.oversample == 4'h0) begin
			half_ticks = 4'd8;
		end else if (line.oversample[3:1] == 3'd0) begin
			half_ticks = 4'd1;
		end else begin
			half_ticks = {1'b0, line.oversample[3:1]};
		end
	end

	assign bit_end  = baud_mx & (bit_cnt == bit_last);
	assign half_end = baud_mx & (bit_cnt == (half_ticks - 4'd1));
	assign cnt_clr  = load | ((state_q == TX_STOP15) ? half_end : bit_end);

	always_ff @(posedge uclk) begin
		if (!urstn) begin
			bit_cnt <= 4'd0;
		end else if (cnt_clr) begin
			bit_cnt <= 4'd0;
		end else if (baud_mx & uart_tx_busy) begin
			bit_cnt <= bit_cnt + 4'd1;
		end
	end

	// ********************
	// frame state machine.
	assign in_data    = state_q[3];
	assign last_bit   = {1'b0, line.lcr_wordlength} + 3'd4;
	assign after_data = line.lcr_parity_enable ? TX_PARITY : TX_STOP1;
	assign after_stop = tx_data_ready ? TX_START : TX_IDLE;

	always_comb begin
		state_d = state_q;
		case (state_q)
			TX_IDLE: begin
				if (baud_mx & tx_data_ready) begin
					state_d = TX_START;
				end
			end
			TX_START: begin
				if (bit_end) begin
					state_d = TX_DATA0;
				end
			end
			TX_PARITY: begin
				if (bit_end) begin
					state_d = TX_STOP1;
				end
			end
			TX_STOP1: begin
				if (bit_end) begin
					if (!line.lcr_stopbit) begin
						state_d = after_stop;
					end else if (line.lcr_wordlength == 2'd0) begin
						state_d = TX_STOP15;
					end else begin
						state_d = TX_STOP2;
					end
				end
			end
			TX_STOP15: begin
				if (half_end) begin
					state_d = after_stop;
				end
			end
			TX_STOP2: begin
				if (bit_end) begin
					state_d = after_stop;
				end
			end
			default: begin
				if (!in_data) begin
					state_d = TX_IDLE;
				end else if (bit_end) begin
					if (state_q[2:0] == last_bit) begin
						state_d = after_data;
					end else begin
						state_d = state_q + 4'd1;
					end
				end
			end
		endcase
	end

	always_ff @(posedge uclk) begin
		if (!urstn) begin
			state_q <= TX_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// character is taken and popped as the start bit begins.
	assign load        = (state_d == TX_START) & (state_q != TX_START);
	assign txfifo_read = load;
	assign shift_en    = in_data & bit_end;

	always_ff @(posedge uclk) begin
		if (load) begin
			shift_q  <= txfifo_dataout;
			parity_q <= 1'b0;
		end else if (shift_en) begin
			shift_q  <= {1'b0, shift_q[7:1]};
			parity_q <= parity_q ^ shift_q[0];
		end
	end

	// ********************
	// line level.
	assign parity_bit = line.lcr_parity_stick ? ~line.lcr_parity_even
		: ~(parity_q ^ line.lcr_parity_even);

	always_comb begin
		if (line.lcr_break) begin
			line_lvl = 1'b0;
		end else if (in_data) begin
			line_lvl = shift_q[0];
		end else if (state_q == TX_START) begin
			line_lvl = 1'b0;
		end else if (state_q == TX_PARITY) begin
			line_lvl = parity_bit;
		end else begin
			line_lvl = 1'b1;
		end
	end

	// pin held at mark in loopback.
	assign uart_sout    = line.uart_loop_mode ? 1'b1 : line_lvl;
	assign unloop_sout  = line_lvl;
	assign uart_tx_busy = (state_q != TX_IDLE);

endmodule

// ==== logic/uart_baud_gen.sv ====
// baud divisor counter, gives a one cycle baud_mx tick every divisor plus one clocks.
`timescale 1ns/100ps

module uart_baud_gen (
	input  logic       uclk,
	input  logic       urstn,
	input  logic [7:0] baud_div,
	output logic       baud_mx
);
	logic [7:0] div_cnt;
	logic       cnt_zero;

	assign cnt_zero = (div_cnt == 8'h00);

	// new divisor is picked up on reload only.
	always_ff @(posedge uclk) begin
		if (!urstn) begin
			div_cnt <= 8'h00;
			baud_mx <= 1'b0;
		end else if (cnt_zero) begin
			div_cnt <= baud_div;
			baud_mx <= 1'b1;
		end else begin
			div_cnt <= div_cnt - 8'h01;
			baud_mx <= 1'b0;
		end
	end

endmodule

// ==== logic/uart_tx_fifo.sv ====
// transmit character fifo between the host write port and the serializer.
`timescale 1ns/100ps
`include "uart_tx_consts.svh"

module uart_tx_fifo (
	input  logic       uclk,
	input  logic       urstn,
	input  logic       push,
	input  logic [7:0] push_data,
	input  logic       txfifo_read,
	output logic [7:0] txfifo_dataout,
	output logic       tx_data_ready,
	output logic       full
);
	logic [7:0]                mem [`UART_TX_FIFO_DEPTH];
	logic [`UART_TX_PTR_W-1:0] wr_ptr;
	logic [`UART_TX_PTR_W-1:0] rd_ptr;
	logic [`UART_TX_PTR_W:0]   count;
	logic                      do_push;
	logic                      do_pop;

	// push when full and pop when empty are dropped.
	assign do_push = push & ~full;
	assign do_pop  = txfifo_read & tx_data_ready;

	always_ff @(posedge uclk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge uclk) begin
		if (!urstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + (`UART_TX_PTR_W)'(1);
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + (`UART_TX_PTR_W)'(1);
			end
			case ({do_push, do_pop})
				2'b10: begin
					count <= count + (`UART_TX_PTR_W+1)'(1);
				end
				2'b01: begin
					count <= count - (`UART_TX_PTR_W+1)'(1);
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	assign txfifo_dataout = mem[rd_ptr];
	assign tx_data_ready  = (count != '0);
	assign full           = (count == (`UART_TX_PTR_W+1)'(`UART_TX_FIFO_DEPTH));

endmodule

// ==== logic/uart_host_port.sv ====
// host write port, decodes register writes into fifo pushes and line control settings.
`timescale 1ns/100ps
`include "uart_tx_consts.svh"

module uart_host_port (
	input  logic                        uclk,
	input  logic                        urstn,
	input  logic                        wr_en,
	input  logic [1:0]                  wr_addr,
	input  uart_tx_pkg::uart_reg_word_u wr_data,
	input  logic                        full,
	output logic                        push,
	output logic [7:0]                  push_data,
	output logic [7:0]                  baud_div,
	output logic                        tx_overrun,
	uart_line_ctrl_if.host              line
);
	import uart_tx_pkg::*;

	uart_lcr_t  lcr_q;
	uart_ctrl_t ctrl_q;
	logic       wr_thr;
	logic       wr_lcr;
	logic       wr_div;
	logic       wr_ctrl;

	assign wr_thr  = wr_en & (wr_addr == `UART_ADDR_THR);
	assign wr_lcr  = wr_en & (wr_addr == `UART_ADDR_LCR);
	assign wr_div  = wr_en & (wr_addr == `UART_ADDR_DIV);
	assign wr_ctrl = wr_en & (wr_addr == `UART_ADDR_CTRL);

	// ********************
	// character path.
	always_ff @(posedge uclk) begin
		if (!urstn) begin
			push <= 1'b0;
		end else begin
			push <= wr_thr;
		end
	end

	always_ff @(posedge uclk) begin
		if (wr_thr) begin
			push_data <= wr_data.raw;
		end
	end

	// sticky until reset.
	always_ff @(posedge uclk) begin
		if (!urstn) begin
			tx_overrun <= 1'b0;
		end else if (push & full) begin
			tx_overrun <= 1'b1;
		end
	end

	// ********************
	// configuration registers.
	always_ff @(posedge uclk) begin
		if (!urstn) begin
			lcr_q    <= '0;
			baud_div <= 8'h00;
			ctrl_q   <= '{loop_mode: 1'b0, ctrl_rsvd: 3'b000,
				oversample: `UART_TX_OVERSAMPLE_DEF};
		end else begin
			if (wr_lcr) begin
				lcr_q <= wr_data.lcr;
			end
			if (wr_div) begin
				baud_div <= wr_data.raw;
			end
			if (wr_ctrl) begin
				ctrl_q <= wr_data.ctrl;
			end
		end
	end

	assign line.lcr_break         = lcr_q.lcr_break;
	assign line.lcr_parity_stick  = lcr_q.lcr_parity_stick;
	assign line.lcr_parity_even   = lcr_q.lcr_parity_even;
	assign line.lcr_parity_enable = lcr_q.lcr_parity_enable;
	assign line.lcr_stopbit       = lcr_q.lcr_stopbit;
	assign line.lcr_wordlength    = lcr_q.lcr_wordlength;
	assign line.oversample        = ctrl_q.oversample;
	assign line.uart_loop_mode    = ctrl_q.loop_mode;

endmodule

// ==== logic/uart_line_ctrl_if.sv ====
// line control settings carried from the host register port to the serializer.
`timescale 1ns/100ps

interface uart_line_ctrl_if;
	logic       lcr_break;
	logic       lcr_parity_stick;
	logic       lcr_parity_even;
	logic       lcr_parity_enable;
	logic       lcr_stopbit;
	logic [1:0] lcr_wordlength;
	logic [3:0] oversample;
	logic       uart_loop_mode;

	modport host (output lcr_break, lcr_parity_stick, lcr_parity_even, lcr_parity_enable,
		lcr_stopbit, lcr_wordlength, oversample, uart_loop_mode);

	modport tx (input lcr_break, lcr_parity_stick, lcr_parity_even, lcr_parity_enable,
		lcr_stopbit, lcr_wordlength, oversample, uart_loop_mode);

endinterface

// ==== logic/uart_tx_pkg.sv ====
// register word types for the transmit subsystem, imported by the host port and the testbench.
package uart_tx_pkg;

	// line control view of a host byte.
	typedef struct packed {
		logic       lcr_break;
		logic       lcr_parity_stick;
		logic       lcr_parity_even;
		logic       lcr_parity_enable;
		logic       lcr_stopbit;
		logic [1:0] lcr_wordlength;
		logic       lcr_rsvd;
	} uart_lcr_t;

	// control view of a host byte.
	typedef struct packed {
		logic       loop_mode;
		logic [2:0] ctrl_rsvd;
		logic [3:0] oversample;
	} uart_ctrl_t;

	// one write byte, read through the view its address selects.
	typedef union packed {
		logic [7:0] raw;
		uart_lcr_t  lcr;
		uart_ctrl_t ctrl;
	} uart_reg_word_u;

endpackage

// ==== include/uart_tx_consts.svh ====
// sizes, host register map and reset defaults shared by the transmit rtl, pulled in by `include.
`ifndef UART_TX_CONSTS_SVH
`define UART_TX_CONSTS_SVH

// transmit fifo geometry.
`define UART_TX_FIFO_DEPTH 16
`define UART_TX_PTR_W 4

// host register addresses.
`define UART_ADDR_THR 2'd0
`define UART_ADDR_LCR 2'd1
`define UART_ADDR_DIV 2'd2
`define UART_ADDR_CTRL 2'd3

// zero selects sixteen ticks per bit.
`define UART_TX_OVERSAMPLE_DEF 4'h0

`endif
